// ==== design/fifo_pkg.sv ====
// Widths are fixed at 32 bits by 8 entries in 4 tiles; tile_width must divide data_width evenly
package fifo_pkg;

  // --------------------
  // Sizes
  // --------------------
  // Entries held by the FIFO, counting the pop output register
  localparam int fifo_depth = 8;
  localparam int data_width = 32;
  // The flop RAM is cut along its width only
  localparam int width_tiles = 4;
  localparam int tile_width = data_width / width_tiles;
  localparam int addr_width = $clog2(fifo_depth);
  // Counts run from 0 to fifo_depth inclusive
  localparam int count_width = $clog2(fifo_depth + 1);

  // --------------------
  // Types
  // --------------------
  typedef logic [data_width-1:0] fifo_data_t;
  typedef logic [tile_width-1:0] tile_data_t;
  typedef logic [addr_width-1:0] fifo_addr_t;
  typedef logic [count_width-1:0] fifo_count_t;

  // One RAM write, shared by all tiles
  typedef struct packed {
    logic       valid;
    fifo_addr_t addr;
    fifo_data_t data;
  } ram_wr_t;

  // Occupancy of the registered pop stage
  typedef enum logic {
    out_empty,
    out_full
  } pop_state_t;

endpackage

// ==== design/fifo_push_ctrl.sv ====
// Sender must push only with a credit in hand; a push is written without checking for overflow
`timescale 1ns/10ps

module fifo_push_ctrl (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 push_credit_stall,
  input  fifo_pkg::fifo_count_t credit_withhold,
  input  logic                 push_valid,
  input  fifo_pkg::fifo_data_t push_data,
  input  logic                 pop_pulse,
  output logic                 push_credit,
  output logic                 push_receiver_in_reset,
  output fifo_pkg::fifo_count_t credit_count,
  output fifo_pkg::fifo_count_t credit_available,
  output fifo_pkg::ram_wr_t    ram_wr,
  output logic                 wr_pulse
);
  import fifo_pkg::*;

  logic        in_reset_q;
  logic        above_withhold;
  fifo_count_t credit_cnt;
  fifo_addr_t  wr_ptr;

  // --------------------
  // Reset indication
  // --------------------
  // The flop stretches the indication one cycle past the fall of rst
  always_ff @(posedge clk) begin
    in_reset_q <= rst;
  end

  // The rst term covers the cycles before the first clock edge
  assign push_receiver_in_reset = rst || in_reset_q;

  // --------------------
  // Credit counter
  // --------------------
  // Credits are only handed out while more than the withheld amount remains
  assign above_withhold = credit_cnt > credit_withhold;

  // Credit return is a combinational pulse in the cycle the condition holds
  assign push_credit = above_withhold && !push_credit_stall && !push_receiver_in_reset;

  // Each issued credit takes a slot, each pop gives one back
  always_ff @(posedge clk) begin
    if (rst) begin
      credit_cnt <= fifo_count_t'(fifo_depth);
    end else if (push_credit && !pop_pulse) begin
      credit_cnt <= credit_cnt - fifo_count_t'(1);
    end else if (pop_pulse && !push_credit) begin
      credit_cnt <= credit_cnt + fifo_count_t'(1);
    end
  end

  assign credit_count = credit_cnt;

  // Credits the receiver could still give out if stall were low
  assign credit_available = above_withhold ? credit_cnt - credit_withhold : '0;

  // --------------------
  // Write side
  // --------------------
  // Pointer wraps naturally since the depth is a power of two
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
    end else if (push_valid) begin
      wr_ptr <= wr_ptr + fifo_addr_t'(1);
    end
  end

  // The push is written at the same edge it arrives, no address or data stage
  assign ram_wr.valid = push_valid;
  assign ram_wr.addr  = wr_ptr;
  assign ram_wr.data  = push_data;

  // The pop controller counts this write at the same edge as the RAM stores it
  assign wr_pulse = push_valid;

endmodule

// ==== design/ram_flops_tile.sv ====
// One width slice of the flop RAM; no reset on storage, and reads of unwritten words are undefined
`timescale 1ns/10ps

module ram_flops_tile (
  input  logic                 clk,
  input  logic                 wr_valid,
  input  fifo_pkg::fifo_addr_t wr_addr,
  input  fifo_pkg::tile_data_t wr_data,
  input  fifo_pkg::fifo_addr_t rd_addr,
  output fifo_pkg::tile_data_t rd_data
);
  import fifo_pkg::*;

  // Storage for this tile's slice of every entry
  tile_data_t mem [fifo_depth];

  // --------------------
  // Write port
  // --------------------
  // A single word is stored per strobe
  always_ff @(posedge clk) begin
    if (wr_valid) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // --------------------
  // Read port
  // --------------------
  // The FIFO never reads the slot being written in the same cycle,
  // so no write-to-read forwarding is needed here
  assign rd_data = mem[rd_addr];

endmodule

// ==== design/fifo_pop_ctrl.sv ====
// Items counts the RAM and the output register together; writes become poppable one cycle later
`timescale 1ns/10ps

module fifo_pop_ctrl (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  wr_pulse,
  input  fifo_pkg::fifo_data_t  rd_data,
  input  logic                  pop_ready,
  output fifo_pkg::fifo_addr_t  rd_addr,
  output logic                  pop_valid,
  output fifo_pkg::fifo_data_t  pop_data,
  output logic                  pop_pulse,
  output fifo_pkg::fifo_count_t items,
  output fifo_pkg::fifo_count_t slots,
  output logic                  full,
  output logic                  empty
);
  import fifo_pkg::*;

  pop_state_t  state;
  pop_state_t  state_next;
  fifo_count_t ram_items;
  fifo_addr_t  rd_ptr;
  logic        load;

  // --------------------
  // Output handshake
  // --------------------
  assign pop_valid = (state == out_full);

  // A transfer frees one credit back on the push side
  assign pop_pulse = pop_valid && pop_ready;

  // --------------------
  // Occupancy
  // --------------------
  // Entries still in the RAM, excluding the one held in the output register.
  // A write from this cycle is not counted yet, so push never reaches pop
  // combinationally
  assign ram_items = items - fifo_count_t'(pop_valid);

  // Refill when the register is free or is being emptied this cycle
  assign load = (ram_items != '0) && (!pop_valid || pop_ready);

  always_ff @(posedge clk) begin
    if (rst) begin
      items <= '0;
    end else if (wr_pulse && !pop_pulse) begin
      items <= items + fifo_count_t'(1);
    end else if (pop_pulse && !wr_pulse) begin
      items <= items - fifo_count_t'(1);
    end
  end

  assign slots = fifo_count_t'(fifo_depth) - items;
  assign full  = (items == fifo_count_t'(fifo_depth));
  assign empty = (items == '0);

  // --------------------
  // Output register FSM
  // --------------------
  always_comb begin
    state_next = state;
    if (load) begin
      state_next = out_full;
    end else if (pop_pulse) begin
      state_next = out_empty;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= out_empty;
    end else begin
      state <= state_next;
    end
  end

  // Read pointer moves once per word handed to the output register
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr <= '0;
    end else if (load) begin
      rd_ptr <= rd_ptr + fifo_addr_t'(1);
    end
  end

  assign rd_addr = rd_ptr;

  // Payload only changes on a load, which keeps it stable under back-pressure
  always_ff @(posedge clk) begin
    if (load) begin
      pop_data <= rd_data;
    end
  end

endmodule

// ==== design/fifo_flops_push_credit.sv ====
// Credit/valid push and ready/valid pop FIFO, 32 by 8, no bypass; push to pop latency is 2 cycles
`timescale 1ns/10ps

module fifo_flops_push_credit (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  push_credit_stall,
  input  fifo_pkg::fifo_count_t credit_withhold,
  input  logic                  push_valid,
  input  fifo_pkg::fifo_data_t  push_data,
  input  logic                  pop_ready,
  output logic                  push_credit,
  output logic                  push_receiver_in_reset,
  output fifo_pkg::fifo_count_t credit_count,
  output fifo_pkg::fifo_count_t credit_available,
  output logic                  pop_valid,
  output fifo_pkg::fifo_data_t  pop_data,
  output fifo_pkg::fifo_count_t items,
  output fifo_pkg::fifo_count_t slots,
  output logic                  full,
  output logic                  empty
);
  import fifo_pkg::*;

  ram_wr_t    ram_wr;
  fifo_addr_t rd_addr;
  fifo_data_t rd_data;
  logic       wr_pulse;
  logic       pop_pulse;

  // --------------------
  // Push side
  // --------------------
  fifo_push_ctrl u_push_ctrl (
    .clk                    (clk),
    .rst                    (rst),
    .push_credit_stall      (push_credit_stall),
    .credit_withhold        (credit_withhold),
    .push_valid             (push_valid),
    .push_data              (push_data),
    .pop_pulse              (pop_pulse),
    .push_credit            (push_credit),
    .push_receiver_in_reset (push_receiver_in_reset),
    .credit_count           (credit_count),
    .credit_available       (credit_available),
    .ram_wr                 (ram_wr),
    .wr_pulse               (wr_pulse)
  );

  // --------------------
  // Flop RAM
  // --------------------
  // Each tile holds one byte lane; all share the write strobe and both addresses
  for (genvar i = 0; i < width_tiles; i++) begin : g_tile
    ram_flops_tile u_tile (
      .clk      (clk),
      .wr_valid (ram_wr.valid),
      .wr_addr  (ram_wr.addr),
      .wr_data  (ram_wr.data[i*tile_width +: tile_width]),
      .rd_addr  (rd_addr),
      .rd_data  (rd_data[i*tile_width +: tile_width])
    );
  end

  // --------------------
  // Pop side
  // --------------------
  fifo_pop_ctrl u_pop_ctrl (
    .clk       (clk),
    .rst       (rst),
    .wr_pulse  (wr_pulse),
    .rd_data   (rd_data),
    .pop_ready (pop_ready),
    .rd_addr   (rd_addr),
    .pop_valid (pop_valid),
    .pop_data  (pop_data),
    .pop_pulse (pop_pulse),
    .items     (items),
    .slots     (slots),
    .full      (full),
    .empty     (empty)
  );

endmodule

// ==== bench/fifo_flops_push_credit_tb.sv ====
// Sender pushes only with held credits; every wait has a timeout and the run ends on its own
`timescale 1ns/10ps

module fifo_flops_push_credit_tb;
  import fifo_pkg::*;

  typedef enum {goal_drained, goal_spent, goal_pops, goal_credits} goal_t;

  logic        clk;
  logic        rst = 1'b1;
  logic        push_credit_stall = 1'b0;
  fifo_count_t credit_withhold = '0;
  logic        push_valid = 1'b0;
  fifo_data_t  push_data = '0;
  logic        pop_ready = 1'b0;
  logic        push_credit;
  logic        push_receiver_in_reset;
  fifo_count_t credit_count;
  fifo_count_t credit_available;
  logic        pop_valid;
  fifo_data_t  pop_data;
  fifo_count_t items;
  fifo_count_t slots;
  logic        full;
  logic        empty;

  int seed = 32'h813dfe21;
  int credit_errors = 0;
  int data_errors = 0;
  int flow_errors = 0;
  int timeouts = 0;
  int credits_seen = 0;
  int credits_held = 0;
  int pushes = 0;
  int pops = 0;
  int pop_mode = 1;   // 0 holds pop_ready low, 1 randomizes it, 2 holds it high
  int base;
  logic       hold_seen = 1'b0;
  fifo_data_t hold_data;

  fifo_flops_push_credit dut (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Expected payload of the nth push, a scramble of the sequence number
  function automatic fifo_data_t ref_word(input int n);
    fifo_data_t x;
    x = fifo_data_t'(n) * 32'h9e3779b1;
    return x ^ {x[15:0], x[31:16]} ^ 32'h5a5a0f0f;
  endfunction

  function automatic bit goal_met(input goal_t goal, input int target);
    case (goal)
      goal_drained: return credits_held == 0 && !push_valid && items == '0 && !pop_valid;
      goal_spent:   return credits_held == 0 && !push_valid;
      goal_pops:    return pops >= target;
      default:      return credits_seen >= target;
    endcase
  endfunction

  task automatic wait_goal(input goal_t goal, input int target, input int limit,
                           input string what);
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!goal_met(goal, target) && cycles < limit);
    if (!goal_met(goal, target)) begin
      timeouts++;
      $display("Timed out after %0d cycles waiting for %s", limit, what);
    end
  endtask

  task automatic check_idle();
    assert (push_receiver_in_reset && !push_credit && !pop_valid && !full && empty
            && slots == 4'd8 && items == 4'd0)
      else begin
        flow_errors++;
        $display("Error at %0t: outputs not idle near reset (credit %b valid %b slots %0d)",
                 $time, push_credit, pop_valid, slots);
      end
  endtask

  // --------------------
  // Sender and receiver stimulus
  // --------------------
  always @(posedge clk) begin
    if (rst) begin
      credits_held = 0;
      push_valid <= 1'b0;
      pop_ready <= 1'b0;
    end else begin
      // Held credits, the push in flight and stored items share the 8 slots
      assert (credits_held + int'(push_valid) + int'(items) <= fifo_depth) else begin
        credit_errors++;
        $display("Error at %0t: %0d held credits and %0d items overrun the depth",
                 $time, credits_held, items);
      end
      if (push_credit) begin
        credits_held++;
        credits_seen++;
      end
      // A push uses one held credit, with a random gap before it
      if (credits_held > 0 && ($random(seed) & 1) != 0) begin
        push_valid <= 1'b1;
        push_data <= ref_word(pushes);
        pushes++;
        credits_held--;
      end else begin
        push_valid <= 1'b0;
      end
      case (pop_mode)
        0:       pop_ready <= 1'b0;
        1:       pop_ready <= ($random(seed) & 1) != 0;
        default: pop_ready <= 1'b1;
      endcase
    end
  end

  // --------------------
  // Pop checker
  // --------------------
  always @(posedge clk) begin
    if (rst) begin
      hold_seen = 1'b0;
    end else begin
      assert (items <= fifo_count_t'(fifo_depth) && full == (items == fifo_count_t'(fifo_depth)))
        else begin
          data_errors++;
          $display("Error at %0t: items %0d with full %b", $time, items, full);
        end
      assert (!(push_credit_stall && push_credit)) else begin
        data_errors++;
        $display("Error at %0t: credit returned while stalled", $time);
      end
      // Under back-pressure the word on offer must not move
      if (hold_seen) begin
        assert (pop_valid && pop_data == hold_data) else begin
          data_errors++;
          $display("Error at %0t: pop output changed while stalled, %h then %h",
                   $time, hold_data, pop_data);
        end
      end
      if (pop_valid && pop_ready) begin
        assert (pop_data == ref_word(pops)) else begin
          data_errors++;
          $display("Error at %0t: pop %0d gave %h, expected %h",
                   $time, pops, pop_data, ref_word(pops));
        end
        pops++;
      end
      hold_seen = pop_valid && !pop_ready;
      hold_data = pop_data;
    end
  end

  // --------------------
  // Test sequence
  // --------------------
  initial begin
    // Two reset edges, outputs checked inside reset and one cycle after it
    @(negedge clk);
    check_idle();
    @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_idle();
    @(negedge clk);
    assert (!push_receiver_in_reset) else begin
      flow_errors++;
      $display("Error at %0t: receiver still in reset two cycles after rst fell", $time);
    end
    wait_goal(goal_pops, 300, 5000, "300 pop transfers");
    // Withholding every slot stops credit so the FIFO can empty
    @(posedge clk);
    credit_withhold <= 4'd8;
    wait_goal(goal_drained, 0, 200, "the FIFO to drain");
    // With 3 withheld and pops blocked only 5 credits may go out
    @(posedge clk);
    credit_withhold <= 4'd3;
    pop_mode <= 0;
    @(negedge clk);
    base = credits_seen;
    // An empty FIFO with 3 withheld has 8 minus 3 credits to give
    assert (credit_count == 4'd8 && credit_available == 4'd5) else begin
      flow_errors++;
      $display("Error at %0t: counter %0d with %0d available under withhold 3",
               $time, credit_count, credit_available);
    end
    wait_goal(goal_credits, base + 5, 50, "five credits with withhold 3");
    repeat (30) @(negedge clk);
    assert (credits_seen == base + 5 && credit_count == 4'd3 && credit_available == 4'd0)
      else begin
        flow_errors++;
        $display("Error at %0t: %0d credits issued with withhold 3, counter %0d",
                 $time, credits_seen - base, credit_count);
      end
    @(posedge clk);
    pop_mode <= 2;
    wait_goal(goal_credits, base + 6, 50, "credits after pop_ready rose");
    // Stall holds back all credit while the FIFO empties
    @(posedge clk);
    push_credit_stall <= 1'b1;
    credit_withhold <= 4'd0;
    @(negedge clk);
    base = credits_seen;
    wait_goal(goal_drained, 0, 200, "the FIFO to drain under stall");
    assert (credits_seen == base) else begin
      flow_errors++;
      $display("Error at %0t: %0d credits seen during stall", $time, credits_seen - base);
    end
    @(posedge clk);
    push_credit_stall <= 1'b0;
    pop_mode <= 0;
    wait_goal(goal_credits, base + 8, 50, "withheld credits after stall");
    // Pops stay blocked, so the eight credits fill every slot and no more follow
    wait_goal(goal_spent, 0, 100, "the sender to use its credits");
    assert (credits_seen == base + 8 && items == 4'd8 && full && !empty && slots == 4'd0
            && pop_valid && credit_count == 4'd0)
      else begin
        flow_errors++;
        $display("Error at %0t: %0d credits after stall left items %0d, full %b, slots %0d",
                 $time, credits_seen - base, items, full, slots);
      end
    @(posedge clk);
    credit_withhold <= 4'd8;
    pop_mode <= 1;
    wait_goal(goal_drained, 0, 200, "the final drain");
    assert (pops == pushes && pops >= 300) else begin
      flow_errors++;
      $display("Error at %0t: %0d pushes but %0d pops", $time, pushes, pops);
    end
    $display("Done: %0d pushes %0d pops, errors credit %0d data %0d flow %0d, timeouts %0d",
             pushes, pops, credit_errors, data_errors, flow_errors, timeouts);
    if (credit_errors + data_errors + flow_errors + timeouts == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
design/fifo_pkg.sv
design/fifo_push_ctrl.sv
design/ram_flops_tile.sv
design/fifo_pop_ctrl.sv
design/fifo_flops_push_credit.sv
bench/fifo_flops_push_credit_tb.sv

// ==== Makefile ====
TOP := fifo_flops_push_credit_tb
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f vlog.f

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f vlog.f -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1 || echo "TESTBENCH FAILED" >> $(LOG)
	cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
